//--- hw/pwm_settings.svh
////////////////////////////////////////
// register map and config bit layout
// for the two channel pwm block
// span of all channels must stay below
// the top of the 8-bit address space
////////////////////////////////////////

`ifndef PWM_SETTINGS_SVH
`define PWM_SETTINGS_SVH

// number of pwm channels behind the bus port
`define NUM_PWM_CHANNELS 2

// first register address of channel 0
`define PWM_BASE 8'h10

// registers per channel, also the address stride
`define NOS_PWM_REGISTERS 4

// register offsets inside one channel
`define PWM_PERIOD  0
`define PWM_ON_TIME 1
`define PWM_CONFIG  2
// read only, writes are dropped
`define PWM_STATUS  3

// config register bit positions
`define PWM_ENABLE       0
`define H_BRIDGE_ENABLE  1
// 3-bit command field, lowest bit given
`define H_BRIDGE_COMMAND 2
`define H_BRIDGE_SWAP    5
// 2-bit per-pin invert field, lowest bit given
`define H_BRIDGE_INVERT  6

`endif

//--- hw/pwm_pkg.sv
////////////////////////////////////////
// shared types for the pwm block
// bus structs follow the four-phase
// request/acknowledge handshake
////////////////////////////////////////

package pwm_pkg;

   // host to block, fields held stable while handshake_1 is up
   typedef struct packed {
      logic        handshake_1;
      // 1 means write
      logic        rw;
      logic [7:0]  reg_address;
      logic [31:0] data;
   } bus_req_t;

   // block to host, data and err valid while handshake_2 is up
   typedef struct packed {
      logic        handshake_2;
      // address outside every channel
      logic        err;
      logic [31:0] data;
   } bus_rsp_t;

   // one-cycle strobe from the bus port to a single channel
   typedef struct packed {
      logic        wr;
      logic        rd;
      logic [1:0]  reg_index;
      logic [31:0] wdata;
   } reg_access_t;

   // bridge command, codes 4 to 7 fall back to coast
   typedef enum logic [2:0] {
      coast   = 3'd0,
      forward = 3'd1,
      reverse = 3'd2,
      brake   = 3'd3
   } bridge_cmd_t;

   // config fields that steer one h-bridge
   typedef struct packed {
      logic        enable;
      bridge_cmd_t command;
      logic        swap;
      logic [1:0]  invert;
   } bridge_cfg_t;

endpackage

//--- hw/bus_port.sv
////////////////////////////////////////
// four-phase bus slave for the pwm block
// ack comes 3 cycles after request seen
// one request in flight at a time
////////////////////////////////////////

`timescale 1ns/10ps
`include "pwm_settings.svh"

module bus_port import pwm_pkg::*; (
   input  logic                                    clk,
   input  logic                                    reset,
   input  bus_req_t                                bus_req,
   output bus_rsp_t                                bus_rsp,
   output reg_access_t [`NUM_PWM_CHANNELS-1:0]     chan_access,
   input  logic [`NUM_PWM_CHANNELS-1:0][31:0]      chan_rdata
);

   typedef enum logic [1:0] {st_idle, st_access, st_ack} port_state_t;

   // step on which the channel read word is ready
   localparam logic [1:0] ack_step = 2'd2;

   port_state_t state_q;
   logic [1:0]  step_q;
   bus_req_t    req_q;
   logic [7:0]  offset;
   logic        in_range;
   logic [1:0]  reg_idx;
   logic [`NUM_PWM_CHANNELS-1:0] match;
   logic [31:0] sel_rdata;

   // request is held here for the whole transaction
   always_ff @(posedge clk) begin
      if (state_q == st_idle && bus_req.handshake_1) begin
         req_q <= bus_req;
      end
   end

   // address decode from the captured request
   assign offset   = req_q.reg_address - `PWM_BASE;
   assign in_range = (req_q.reg_address >= `PWM_BASE) &&
                     (offset < `NUM_PWM_CHANNELS * `NOS_PWM_REGISTERS);
   assign reg_idx  = 2'(offset % `NOS_PWM_REGISTERS);

   // one-hot channel select plus read word mux
   always_comb begin
      sel_rdata = '0;
      for (int i = 0; i < `NUM_PWM_CHANNELS; i++) begin
         match[i] = in_range && ((offset / `NOS_PWM_REGISTERS) == i);
         if (match[i]) begin
            sel_rdata = chan_rdata[i];
         end
      end
   end

   // handshake fsm, strobe and response registers
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state_q     <= st_idle;
         step_q      <= '0;
         bus_rsp     <= '0;
         chan_access <= '0;
      end else begin
         for (int i = 0; i < `NUM_PWM_CHANNELS; i++) begin
            // strobe lasts a single cycle
            chan_access[i].wr        <= (state_q == st_access) && (step_q == '0) &&
                                        match[i] && req_q.rw;
            chan_access[i].rd        <= (state_q == st_access) && (step_q == '0) &&
                                        match[i] && !req_q.rw;
            chan_access[i].reg_index <= reg_idx;
            chan_access[i].wdata     <= req_q.data;
         end
         case (state_q)
            st_idle: begin
               step_q <= '0;
               if (bus_req.handshake_1) begin
                  state_q <= st_access;
               end
            end
            st_access: begin
               step_q <= step_q + 2'd1;
               // channel read word registered one cycle after the strobe
               if (step_q == ack_step) begin
                  state_q             <= st_ack;
                  bus_rsp.handshake_2 <= 1'b1;
                  bus_rsp.err         <= !in_range;
                  bus_rsp.data        <= req_q.rw ? '0 : sel_rdata;
               end
            end
            st_ack: begin
               // host dropped its request, close the handshake
               if (!bus_req.handshake_1) begin
                  state_q             <= st_idle;
                  bus_rsp.handshake_2 <= 1'b0;
               end
            end
            default: state_q <= st_idle;
         endcase
      end
   end

   // host must hold the request until it sees the acknowledge
   req_stable: assert property (@(posedge clk) disable iff (!reset)
      (bus_req.handshake_1 && !bus_rsp.handshake_2) |=>
      (!bus_req.handshake_1 || bus_rsp.handshake_2 || $stable(bus_req)))
      else $error("bus request changed before acknowledge");

endmodule

//--- hw/pwm_channel.sv
////////////////////////////////////////
// one pwm channel with its registers
// writing period or on-time drops enable
// period 0 or enable low keeps pulse low
////////////////////////////////////////

`timescale 1ns/10ps
`include "pwm_settings.svh"

module pwm_channel import pwm_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  reg_access_t access,
   output logic [31:0] rdata,
   output logic        pulse,
   output bridge_cfg_t bridge_cfg
);

   // programmed values, in clock cycles
   logic [31:0] period_q;
   logic [31:0] on_time_q;
   logic [31:0] cfg_q;

   // position inside the current period
   logic [31:0] count_q;
   logic        run;
   logic [31:0] status;

   // register writes from the bus port strobe
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         period_q  <= '0;
         on_time_q <= '0;
         cfg_q     <= '0;
      end else if (access.wr) begin
         case (access.reg_index)
            2'(`PWM_PERIOD): begin
               period_q <= access.wdata;
               // new timing must be re-enabled by software
               cfg_q[`PWM_ENABLE] <= 1'b0;
            end
            2'(`PWM_ON_TIME): begin
               on_time_q <= access.wdata;
               cfg_q[`PWM_ENABLE] <= 1'b0;
            end
            2'(`PWM_CONFIG): begin
               cfg_q <= access.wdata;
            end
            // status is read only
            default: begin
            end
         endcase
      end
   end

   // counting only with a non-zero period
   assign run = cfg_q[`PWM_ENABLE] && (period_q != '0);

   // counter wraps at period - 1
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         count_q <= '0;
      end else if (!run) begin
         count_q <= '0;
      end else if (count_q >= period_q - 32'd1) begin
         count_q <= '0;
      end else begin
         count_q <= count_q + 32'd1;
      end
   end

   // high for the first on-time counts of each period
   // on-time >= period gives a constant high
   assign pulse = run && (count_q < on_time_q);

   // pulse on top, lower half of config below
   assign status = {pulse, 15'b0, cfg_q[15:0]};

   // read word lands one cycle after the rd strobe
   always_ff @(posedge clk) begin
      if (access.rd) begin
         case (access.reg_index)
            2'(`PWM_PERIOD):  rdata <= period_q;
            2'(`PWM_ON_TIME): rdata <= on_time_q;
            2'(`PWM_CONFIG):  rdata <= cfg_q;
            default:          rdata <= status;
         endcase
      end
   end

   // config fields for the h-bridge decoder
   assign bridge_cfg.enable  = cfg_q[`H_BRIDGE_ENABLE];
   assign bridge_cfg.command = bridge_cmd_t'(cfg_q[`H_BRIDGE_COMMAND +: 3]);
   assign bridge_cfg.swap    = cfg_q[`H_BRIDGE_SWAP];
   assign bridge_cfg.invert  = cfg_q[`H_BRIDGE_INVERT +: 2];

   // the count never reaches the period while the channel runs
   count_in_period: assert property (@(posedge clk) disable iff (!reset)
      run |-> (count_q < period_q))
      else $error("pwm counter ran past the period");

endmodule

//--- hw/h_bridge.sv
////////////////////////////////////////
// h-bridge pin decode, combinational
// command codes 4 to 7 act as coast
// swap applies before the pin inversion
////////////////////////////////////////

`timescale 1ns/10ps

module h_bridge import pwm_pkg::*; (
   input  logic        pulse,
   input  bridge_cfg_t bridge_cfg,
   output logic        h_bridge_1,
   output logic        h_bridge_2
);

   // pin levels straight from the command
   logic raw_1;
   logic raw_2;
   // pin levels after the optional swap
   logic pin_1;
   logic pin_2;

   always_comb begin
      raw_1 = 1'b0;
      raw_2 = 1'b0;
      if (bridge_cfg.enable) begin
         case (bridge_cfg.command)
            forward: begin
               raw_1 = pulse;
            end
            reverse: begin
               raw_2 = pulse;
            end
            brake: begin
               // both low-side paths on
               raw_1 = 1'b1;
               raw_2 = 1'b1;
            end
            // coast and unused codes leave both pins low
            default: begin
            end
         endcase
      end
   end

   // exchange pins for a motor wired the other way round
   assign pin_1 = bridge_cfg.swap ? raw_2 : raw_1;
   assign pin_2 = bridge_cfg.swap ? raw_1 : raw_2;

   // per-pin polarity for active-low drivers
   assign h_bridge_1 = pin_1 ^ bridge_cfg.invert[0];
   assign h_bridge_2 = pin_2 ^ bridge_cfg.invert[1];

   // shoot-through guard, both legs only on an enabled brake
   always_comb begin
      assert #0 (!(raw_1 && raw_2) ||
                 (bridge_cfg.enable && bridge_cfg.command == brake))
         else $error("both bridge pins high outside brake");
   end

endmodule

//--- hw/pwm_subsystem.sv
////////////////////////////////////////
// pwm block top, bus port and channels
// each channel drives one h-bridge pair
// pins come straight from the decoders
////////////////////////////////////////

`timescale 1ns/10ps
`include "pwm_settings.svh"

module pwm_subsystem import pwm_pkg::*; (
   input  logic                         clk,
   input  logic                         reset,
   input  bus_req_t                     bus_req,
   output bus_rsp_t                     bus_rsp,
   output logic [`NUM_PWM_CHANNELS-1:0] pwm_signal,
   output logic [`NUM_PWM_CHANNELS-1:0] h_bridge_1,
   output logic [`NUM_PWM_CHANNELS-1:0] h_bridge_2
);

   // strobes out to the channels
   reg_access_t [`NUM_PWM_CHANNELS-1:0]   chan_access;
   // read words back from the channels
   logic [`NUM_PWM_CHANNELS-1:0][31:0]    chan_rdata;

   // handshake and address decode
   bus_port u_bus_port (
      .clk         (clk),
      .reset       (reset),
      .bus_req     (bus_req),
      .bus_rsp     (bus_rsp),
      .chan_access (chan_access),
      .chan_rdata  (chan_rdata)
   );

   // one channel and one decoder per pwm output
   for (genvar i = 0; i < `NUM_PWM_CHANNELS; i++) begin : g_chan

      // config fields from channel to its decoder
      bridge_cfg_t bridge_cfg;

      pwm_channel u_pwm_channel (
         .clk        (clk),
         .reset      (reset),
         .access     (chan_access[i]),
         .rdata      (chan_rdata[i]),
         .pulse      (pwm_signal[i]),
         .bridge_cfg (bridge_cfg)
      );

      // decoder sees the same pulse that leaves the block
      h_bridge u_h_bridge (
         .pulse      (pwm_signal[i]),
         .bridge_cfg (bridge_cfg),
         .h_bridge_1 (h_bridge_1[i]),
         .h_bridge_2 (h_bridge_2[i])
      );

   end

endmodule

//--- dv/tb_pwm_subsystem.sv
////////////////////////////////////////
// self-checking bench for the pwm block
// outputs sampled on the falling edge
// stops at the first failing check
////////////////////////////////////////

`timescale 1ns/10ps
`include "pwm_settings.svh"

module tb_pwm_subsystem import pwm_pkg::*; ();

   localparam int          timeout_cycles = 400;
   localparam logic [31:0] lfsr_seed      = 32'h389e889a;

   // one table row with pins given as {h_bridge_2, h_bridge_1}
   typedef struct packed {
      logic [7:0]  chan;
      logic [7:0]  period;
      logic [7:0]  on_time;
      logic [31:0] cfg;
      logic [7:0]  exp_on;
      logic [7:0]  exp_per;
      logic [1:0]  pins_hi;
      logic [1:0]  pins_lo;
   } row_t;

   logic                         clk;
   logic                         reset;
   bus_req_t                     bus_req;
   bus_rsp_t                     bus_rsp;
   logic [`NUM_PWM_CHANNELS-1:0] pwm_signal;
   logic [`NUM_PWM_CHANNELS-1:0] h_bridge_1;
   logic [`NUM_PWM_CHANNELS-1:0] h_bridge_2;
   row_t                         rows[$];
   string                        row_names[$];
   logic [31:0]                  lfsr_state;

   pwm_subsystem u_pwm_subsystem (
      .clk        (clk),
      .reset      (reset),
      .bus_req    (bus_req),
      .bus_rsp    (bus_rsp),
      .pwm_signal (pwm_signal),
      .h_bridge_1 (h_bridge_1),
      .h_bridge_2 (h_bridge_2)
   );

   // 100 ns clock
   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Test failed");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (expected === actual)
         else report_failure($sformatf("mismatch %s expected %0h actual %0h",
                                       name, expected, actual));
   endtask

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic logic [7:0] reg_address(input int chan, input int idx);
      return 8'(`PWM_BASE + chan * `NOS_PWM_REGISTERS + idx);
   endfunction

   // one full four-phase handshake
   task automatic bus_xfer(input logic rw, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      int wait_cnt;
      @(posedge clk);
      bus_req <= '{handshake_1: 1'b1, rw: rw, reg_address: addr, data: wdata};
      wait_cnt = 0;
      @(negedge clk);
      while (!bus_rsp.handshake_2) begin
         wait_cnt++;
         if (wait_cnt > timeout_cycles) report_failure("timeout waiting for bus acknowledge");
         @(negedge clk);
      end
      // data and err valid while the acknowledge is up
      rdata = bus_rsp.data;
      err   = bus_rsp.err;
      @(posedge clk);
      bus_req.handshake_1 <= 1'b0;
      wait_cnt = 0;
      @(negedge clk);
      while (bus_rsp.handshake_2) begin
         wait_cnt++;
         if (wait_cnt > timeout_cycles) report_failure("timeout waiting for acknowledge to drop");
         @(negedge clk);
      end
   endtask

   task automatic bus_write(input string name, input int chan, input int idx,
                            input logic [31:0] data);
      logic [31:0] rdata;
      logic        err;
      bus_xfer(1'b1, reg_address(chan, idx), data, rdata, err);
      check_value({name, " write err"}, 32'h0, 32'(err));
   endtask

   task automatic bus_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
      bus_xfer(1'b0, addr, 32'h0, data, err);
   endtask

   task automatic read_check(input string name, input int chan, input int idx,
                             input logic [31:0] expected);
      logic [31:0] data;
      logic        err;
      bus_read(reg_address(chan, idx), data, err);
      check_value({name, " read err"}, 32'h0, 32'(err));
      check_value(name, expected, data);
   endtask

   task automatic add_row(input string name, input int chan, input int period, input int on_time,
                          input logic [31:0] cfg, input int exp_on, input int exp_per,
                          input logic [1:0] pins_hi, input logic [1:0] pins_lo);
      row_t r;
      r.chan    = 8'(chan);
      r.period  = 8'(period);
      r.on_time = 8'(on_time);
      r.cfg     = cfg;
      r.exp_on  = 8'(exp_on);
      r.exp_per = 8'(exp_per);
      r.pins_hi = pins_hi;
      r.pins_lo = pins_lo;
      rows.push_back(r);
      row_names.push_back(name);
   endtask

   // pins follow the sampled pulse level
   task automatic check_pins(input string name, input int chan, input row_t r);
      logic [1:0] expected;
      expected = pwm_signal[chan] ? r.pins_hi : r.pins_lo;
      check_value({name, " pins"}, 32'(expected), 32'({h_bridge_2[chan], h_bridge_1[chan]}));
   endtask

   task automatic run_row(input int idx);
      row_t        r;
      string       name;
      logic [31:0] rdata;
      logic        err;
      int          chan;
      int          hi_cnt;
      int          per_cnt;
      int          wait_cnt;
      logic        seen_low;
      logic        prev;
      r    = rows[idx];
      name = row_names[idx];
      chan = int'(r.chan);
      bus_write(name, chan, `PWM_PERIOD, 32'(r.period));
      bus_write(name, chan, `PWM_ON_TIME, 32'(r.on_time));
      bus_write(name, chan, `PWM_CONFIG, r.cfg | 32'h1);
      // status holds config low half and zeros above it
      bus_read(reg_address(chan, `PWM_STATUS), rdata, err);
      check_value({name, " status err"}, 32'h0, 32'(err));
      check_value({name, " status cfg"}, (r.cfg | 32'h1) & 32'hffff, {16'h0, rdata[15:0]});
      check_value({name, " status zeros"}, 32'h0, {17'h0, rdata[30:16]});
      if (r.exp_on == 0 || r.exp_on == r.exp_per) begin
         // a steady pulse level shows up in the top status bit
         check_value({name, " status pulse"}, 32'(r.exp_on != 0), 32'(rdata[31]));
         // no edges so the level holds over two periods
         repeat (2 * r.exp_per) begin
            @(negedge clk);
            check_value({name, " level"}, 32'(r.exp_on != 0), 32'(pwm_signal[chan]));
            check_pins(name, chan, r);
         end
      end else begin
         wait_cnt = 0;
         @(negedge clk);
         prev = pwm_signal[chan];
         @(negedge clk);
         while (!(pwm_signal[chan] && !prev)) begin
            prev = pwm_signal[chan];
            wait_cnt++;
            if (wait_cnt > timeout_cycles) report_failure({name, " saw no rising pulse edge"});
            @(negedge clk);
         end
         // count from this rising edge to the next one
         hi_cnt   = 1;
         per_cnt  = 1;
         seen_low = 1'b0;
         check_pins(name, chan, r);
         @(negedge clk);
         while (!(pwm_signal[chan] && seen_low)) begin
            check_pins(name, chan, r);
            if (!pwm_signal[chan]) seen_low = 1'b1;
            else hi_cnt++;
            per_cnt++;
            if (per_cnt > timeout_cycles) report_failure({name, " pulse never repeated"});
            @(negedge clk);
         end
         check_value({name, " on cycles"}, 32'(r.exp_on), 32'(hi_cnt));
         check_value({name, " period"}, 32'(r.exp_per), 32'(per_cnt));
      end
   endtask

   task automatic register_round_trip();
      logic [31:0] cfg_val;
      for (int ch = 0; ch < `NUM_PWM_CHANNELS; ch++) begin
         cfg_val = 32'h00c35aa5 + 32'(ch) * 32'h10000;
         bus_write("cfg", ch, `PWM_CONFIG, cfg_val);
         read_check("cfg readback", ch, `PWM_CONFIG, cfg_val);
         // period still zero so the pulse bit reads low
         read_check("status readback", ch, `PWM_STATUS, cfg_val & 32'h0000ffff);
         // period write drops the enable bit
         bus_write("period", ch, `PWM_PERIOD, 32'h1234 + 32'(ch));
         read_check("cfg after period", ch, `PWM_CONFIG, cfg_val & ~32'h1);
         bus_write("cfg", ch, `PWM_CONFIG, cfg_val);
         bus_write("on time", ch, `PWM_ON_TIME, 32'h0567 + 32'(ch));
         read_check("cfg after on time", ch, `PWM_CONFIG, cfg_val & ~32'h1);
         read_check("period readback", ch, `PWM_PERIOD, 32'h1234 + 32'(ch));
         read_check("on time readback", ch, `PWM_ON_TIME, 32'h0567 + 32'(ch));
      end
      // channel 1 untouched by channel 0 writes
      bus_write("isolation", 0, `PWM_PERIOD, 32'h00ff);
      bus_write("isolation", 0, `PWM_STATUS, 32'hffff_ffff);
      read_check("isolation period", 1, `PWM_PERIOD, 32'h1235);
      read_check("isolation on time", 1, `PWM_ON_TIME, 32'h0568);
      read_check("isolation cfg", 1, `PWM_CONFIG, 32'h00c45aa4);
   endtask

   task automatic bad_address_check(input logic [7:0] addr);
      logic [31:0] data;
      logic        err;
      bus_read(addr, data, err);
      check_value($sformatf("bad address %0h err", addr), 32'h1, 32'(err));
      check_value($sformatf("bad address %0h data", addr), 32'h0, data);
   endtask

   initial begin
      int p;
      int t;
      bus_req    = '0;
      reset      = 1'b0;
      lfsr_state = lfsr_seed;
      repeat (3) @(posedge clk);
      reset <= 1'b1;
      // name, chan, period, on-time, config, on cycles, period, pins high, pins low
      add_row("coast_ch0",        0, 10, 3,  32'h02, 3,  10, 2'b00, 2'b00);
      add_row("forward_ch1",      1, 8,  5,  32'h06, 5,  8,  2'b01, 2'b00);
      add_row("reverse_swap_ch0", 0, 6,  2,  32'h2a, 2,  6,  2'b01, 2'b00);
      add_row("brake_inv1_ch1",   1, 5,  4,  32'h4e, 4,  5,  2'b10, 2'b10);
      add_row("forward_inv_ch0",  0, 7,  1,  32'hc6, 1,  7,  2'b10, 2'b11);
      add_row("bridge_off_ch1",   1, 9,  9,  32'h84, 9,  9,  2'b10, 2'b10);
      add_row("zero_on_ch0",      0, 4,  0,  32'h06, 0,  4,  2'b01, 2'b00);
      add_row("long_on_ch1",      1, 12, 20, 32'h0a, 12, 12, 2'b10, 2'b00);
      add_row("unused_cmd_ch0",   0, 6,  3,  32'h16, 3,  6,  2'b00, 2'b00);
      // extra forward rows with period and on-time in 1 to 20
      for (int k = 0; k < 4; k++) begin
         p = 1 + int'(take_bits(5) % 20);
         t = 1 + int'(take_bits(5) % 20);
         add_row($sformatf("lfsr_%0d", k), k % 2, p, t, 32'h06, (t < p) ? t : p, p,
                 2'b01, 2'b00);
      end
      register_round_trip();
      bad_address_check(8'h08);
      bad_address_check(8'h18);
      bad_address_check(8'hff);
      for (int i = 0; i < rows.size(); i++) begin
         run_row(i);
      end
      $display("Test passed");
      $finish;
   end

endmodule

//--- compile.f
+incdir+hw
hw/pwm_pkg.sv
hw/bus_port.sv
hw/pwm_channel.sv
hw/h_bridge.sv
hw/pwm_subsystem.sv
dv/tb_pwm_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the pwm block testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
   -f compile.f --top-module tb_pwm_subsystem -Mdir obj_dir -o sim_pwm
build_status=$?
if [ "$build_status" -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

sim_output=$(./obj_dir/sim_pwm 2>&1)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "Test passed" <<< "$sim_output"; then
   echo "pwm testbench run ok"
   exit 0
else
   echo "pwm testbench run did not pass"
   exit 1
fi
